//--- balance_store.sv
// Two-entry balance memory, both entries reset to the initial balance; p1 stored before p2
`include "bank_defines.svh"

module balance_store (
	input  logic                          clock,
	input  logic                          rst,
	input  bank_ctrl_pkg::step_ctrl_t     step_ctrl,
	input  bank_types_pkg::balance_pair_t new_balances,
	output bank_types_pkg::balance_pair_t balances,
	output logic                          done_store
);

	bank_types_pkg::balance_t mem [2];
	bank_types_pkg::balance_t wr_data;
	logic                     rd_en;
	logic                     wr_en;
	logic                     wr_idx;

	assign rd_en = (step_ctrl.step == bank_ctrl_pkg::step_read);
	assign wr_en = (step_ctrl.step == bank_ctrl_pkg::step_store);

	// Entry 0 in the first store cycle, entry 1 in the second
	assign wr_idx  = ~step_ctrl.step_first;
	assign wr_data = wr_idx ? new_balances.p2 : new_balances.p1;

	// Read is a single cycle, store ends with the second write
	assign done_store = rd_en | (wr_en & wr_idx);

	always_ff @(posedge clock) begin
		if (rst) begin
			mem[0]      <= `BANK_INIT_BALANCE;
			mem[1]      <= `BANK_INIT_BALANCE;
			balances.p1 <= `BANK_INIT_BALANCE;
			balances.p2 <= `BANK_INIT_BALANCE;
		end else begin
			if (rd_en) begin
				balances.p1 <= mem[0];
				balances.p2 <= mem[1];
			end
			if (wr_en) begin
				mem[wr_idx] <= wr_data;
				// Keep the outputs in step with the memory
				if (wr_idx) begin
					balances.p2 <= wr_data;
				end else begin
					balances.p1 <= wr_data;
				end
			end
		end
	end

	// Writes only happen inside the store step
	a_write_in_store: assert property (@(posedge clock) disable iff (rst)
		$rose(wr_en) |-> $past(step_ctrl.step) == bank_ctrl_pkg::step_travel);

	// The p1 write is always followed by the p2 write
	a_write_pair: assert property (@(posedge clock) disable iff (rst)
		(wr_en && !wr_idx) |=> (wr_en && wr_idx));

endmodule

//--- bank_ctrl_pkg.sv
// Control encodings shared by the sequencer and the units it steps; step values are fixed
package bank_ctrl_pkg;

	// Button decode FSM
	typedef enum logic [1:0] {
		idle          = 2'd0,
		amount_loaded = 2'd1,
		key_loaded    = 2'd2,
		busy          = 2'd3
	} main_state_t;

	// Transaction steps in the order they run
	typedef enum logic [2:0] {
		step_idle   = 3'd0,
		step_read   = 3'd1,
		step_verify = 3'd2,
		step_travel = 3'd3,
		step_store  = 3'd4,
		step_finish = 3'd5
	} step_t;

	// Current step plus a flag for its first cycle
	typedef struct packed {
		step_t step;
		logic  step_first;
	} step_ctrl_t;

endpackage

//--- bank_defines.svh
// Widths, reset balance, accepted key and travel length; balance width must exceed amount width
`ifndef BANK_DEFINES_SVH
`define BANK_DEFINES_SVH

// Stored balance width
`define BANK_BALANCE_W 11

// Amount and key share the switch field, so one width for both
`define BANK_AMOUNT_W 8

// Both players start with this
`define BANK_INIT_BALANCE 11'd1000

// The only key a transaction accepts
`define BANK_KEY_CODE 8'hA5

// Cycles spent in the travel step, at least 1
`define BANK_TRAVEL_CYCLES 4

// Largest value a balance can hold
`define BANK_BALANCE_MAX ((1 << `BANK_BALANCE_W) - 1)

`endif

//--- bank_main.f
+incdir+.
bank_types_pkg.sv
bank_ctrl_pkg.sv
main_control.sv
transaction_control.sv
datapath.sv
balance_store.sv
bank_main.sv
bank_main_tb.sv

//--- bank_main.sv
// Board top level; buttons are active low, outputs are valid from finished until the next start
module bank_main (
	input  logic                     clock,
	input  logic                     rst,
	input  logic [9:0]               sw,
	input  logic [3:0]               key,
	output bank_types_pkg::balance_t p1_balance,
	output bank_types_pkg::balance_t p2_balance,
	output bank_types_pkg::status_t  status,
	output logic                     finished,
	output logic                     busy
);

	bank_ctrl_pkg::step_ctrl_t     step_ctrl;
	bank_types_pkg::balance_pair_t balances;
	bank_types_pkg::balance_pair_t new_balances;
	logic                          load_amount;
	logic                          load_key;
	logic                          start_txn;
	logic                          done_verify;
	logic                          done_store;
	logic                          done_step;

	// Decode stage
	main_control main_control_inst (
		.clock(clock), .rst(rst), .key(key), .finished(finished),
		.load_amount(load_amount), .load_key(load_key),
		.start_txn(start_txn), .busy(busy)
	);

	// Only one unit works in any step
	assign done_step = done_verify | done_store;

	// Execute stage
	transaction_control transaction_control_inst (
		.clock(clock), .rst(rst), .start_txn(start_txn), .done_step(done_step),
		.step_ctrl(step_ctrl), .finished(finished)
	);

	datapath datapath_inst (
		.clock(clock), .rst(rst), .step_ctrl(step_ctrl),
		.load_amount(load_amount), .load_key(load_key), .sw(sw),
		.balances(balances), .new_balances(new_balances),
		.status(status), .done_verify(done_verify)
	);

	// Result stage
	balance_store balance_store_inst (
		.clock(clock), .rst(rst), .step_ctrl(step_ctrl),
		.new_balances(new_balances), .balances(balances), .done_store(done_store)
	);

	assign p1_balance = balances.p1;
	assign p2_balance = balances.p2;

endmodule

//--- bank_main_tb.sv
// Random transfers against a balance model; both players start equal, so the sum stays fixed
`include "bank_defines.svh"

module bank_main_tb;

	localparam int CLK_PERIOD      = 100;
	localparam int NUM_RANDOM      = 24;
	localparam int NUM_BAD_KEY     = 6;
	// Random, bad key, up to 8 draining, 2 near the limit, 2 idle checks
	localparam int NUM_TXN         = NUM_RANDOM + NUM_BAD_KEY + 8 + 2 + 2;
	localparam int WATCHDOG_CYCLES = NUM_TXN * 40 + 200;

	logic                     clock;
	logic                     rst;
	logic [9:0]               sw;
	logic [3:0]               key;
	bank_types_pkg::balance_t p1_balance;
	bank_types_pkg::balance_t p2_balance;
	bank_types_pkg::status_t  status;
	logic                     finished;
	logic                     busy;

	int                       model_p1;
	int                       model_p2;
	int                       checks;
	int                       errors;

	bank_main bank_main_inst (
		.clock(clock), .rst(rst), .sw(sw), .key(key),
		.p1_balance(p1_balance), .p2_balance(p2_balance),
		.status(status), .finished(finished), .busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog expired before the tests completed");
		$display("Some tests failed");
		$finish;
	end

	task automatic compare_value(input string test_name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic press_button(input int idx);
		key[idx] = 1'b0;
		repeat (2) @(negedge clock);
		key[idx] = 1'b1;
		repeat (2) @(negedge clock);
	endtask

	// Key first, then funds, then payee headroom
	task automatic model_apply(input logic payer, input int amount, input int code,
			output bank_types_pkg::status_t exp_status);
		int payer_bal;
		int payee_bal;
		payer_bal = payer ? model_p2 : model_p1;
		payee_bal = payer ? model_p1 : model_p2;
		if (code != int'(`BANK_KEY_CODE)) begin
			exp_status = bank_types_pkg::status_bad_key;
		end else if (payer_bal < amount) begin
			exp_status = bank_types_pkg::status_no_funds;
		end else if (payee_bal + amount > `BANK_BALANCE_MAX) begin
			exp_status = bank_types_pkg::status_overflow;
		end else begin
			exp_status = bank_types_pkg::status_ok;
			if (payer) begin
				model_p2 = model_p2 - amount;
				model_p1 = model_p1 + amount;
			end else begin
				model_p1 = model_p1 - amount;
				model_p2 = model_p2 + amount;
			end
		end
	endtask

	task automatic wait_finished(input string test_name);
		int n;
		n = 0;
		while (finished !== 1'b1 && n < 40) begin
			@(negedge clock);
			n++;
		end
		if (finished !== 1'b1) begin
			errors++;
			$display("ERROR: %s finished did not arrive within 40 cycles", test_name);
		end
	endtask

	task automatic check_balances(input string test_name);
		compare_value({test_name, " p1_balance"}, model_p1, int'(p1_balance));
		compare_value({test_name, " p2_balance"}, model_p2, int'(p2_balance));
	endtask

	// No finished pulse may show up in the next 30 cycles
	task automatic check_quiet(input string test_name);
		int pulses;
		pulses = 0;
		repeat (30) begin
			@(negedge clock);
			if (finished === 1'b1) pulses++;
		end
		if (pulses != 0) begin
			errors++;
			$display("ERROR: %s saw %0d unexpected finished pulses", test_name, pulses);
		end
		check_balances(test_name);
	endtask

	task automatic run_transaction(input logic payer, input logic [7:0] amount,
			input logic [7:0] code, input bit press_when_busy, input string test_name);
		bank_types_pkg::status_t exp_status;
		sw = {1'b0, payer, amount};
		press_button(1);
		sw = {1'b0, payer, code};
		press_button(1);
		press_button(0);
		if (press_when_busy) begin
			if (busy !== 1'b1) begin
				errors++;
				$display("ERROR: %s busy was low after the start press", test_name);
			end
			press_button(0);
		end
		model_apply(payer, int'(amount), int'(code), exp_status);
		wait_finished(test_name);
		check_balances(test_name);
		compare_value({test_name, " status"}, int'(exp_status), int'(status));
	endtask

	initial begin
		logic       payer;
		logic [7:0] amount;
		logic [7:0] code;
		int         payer_bal;
		int         drains;
		void'($urandom(32'h589b6e64));
		rst      = 1'b1;
		sw       = '0;
		key      = 4'hF;
		checks   = 0;
		errors   = 0;
		model_p1 = `BANK_INIT_BALANCE;
		model_p2 = `BANK_INIT_BALANCE;
		repeat (2) @(negedge clock);
		rst = 1'b0;

		check_balances("reset");
		compare_value("reset status", int'(bank_types_pkg::status_ok), int'(status));

		// Accepted transfers, amount clipped to what the payer holds
		for (int i = 0; i < NUM_RANDOM; i++) begin
			payer     = 1'($urandom_range(0, 1));
			amount    = 8'($urandom_range(0, 255));
			payer_bal = payer ? model_p2 : model_p1;
			if (int'(amount) > payer_bal) amount = 8'(payer_bal);
			run_transaction(payer, amount, `BANK_KEY_CODE, 1'b0, "random_ok");
		end

		for (int i = 0; i < NUM_BAD_KEY; i++) begin
			code = 8'($urandom_range(0, 255));
			if (code == `BANK_KEY_CODE) code = code ^ 8'h01;
			run_transaction(1'($urandom_range(0, 1)), 8'($urandom_range(1, 255)), code,
				1'b0, "bad_key");
		end

		// Drain player 1 until a full amount no longer fits
		drains = 0;
		while (model_p1 >= 255 && drains < 8) begin
			run_transaction(1'b0, 8'd255, `BANK_KEY_CODE, 1'b0, "drain");
			drains++;
		end
		run_transaction(1'b0, 8'd255, `BANK_KEY_CODE, 1'b0, "no_funds");
		compare_value("no_funds drained status", int'(bank_types_pkg::status_no_funds),
			int'(status));

		// Payee pushed to the fixed total; the sum never passes the balance limit
		run_transaction(1'b0, 8'(model_p1), `BANK_KEY_CODE, 1'b0, "near_max");
		run_transaction(1'b0, 8'd48, `BANK_KEY_CODE, 1'b0, "near_max_again");

		sw = 10'($urandom_range(0, 1023));
		press_button(0);
		check_quiet("start_without_load");

		run_transaction(1'b1, 8'd100, `BANK_KEY_CODE, 1'b1, "press_while_busy");
		check_quiet("press_while_busy_after");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- bank_types_pkg.sv
// Data types of the payment path; sizes follow bank_defines.svh, player 0 is player 1
`include "bank_defines.svh"

package bank_types_pkg;

	// Amount entered on the switches
	typedef logic [`BANK_AMOUNT_W-1:0] amount_t;

	// Key code entered on the switches
	typedef logic [`BANK_AMOUNT_W-1:0] key_code_t;

	// Balance as held in the store
	typedef logic [`BANK_BALANCE_W-1:0] balance_t;

	// 0 is player 1, 1 is player 2
	typedef logic player_t;

	// One pending transfer
	typedef struct packed {
		player_t   payer;
		amount_t   amount;
		key_code_t key_code;
	} request_t;

	// Both balances, always moved together
	typedef struct packed {
		balance_t p1;
		balance_t p2;
	} balance_pair_t;

	// Outcome of the last verify, first failing check wins
	typedef enum logic [1:0] {
		status_ok       = 2'd0,
		status_bad_key  = 2'd1,
		status_no_funds = 2'd2,
		status_overflow = 2'd3
	} status_t;

endpackage

//--- datapath.sv
// Request latch and verify checks; results change only in verify, sw[8] picks the payer
`include "bank_defines.svh"

module datapath (
	input  logic                          clock,
	input  logic                          rst,
	input  bank_ctrl_pkg::step_ctrl_t     step_ctrl,
	input  logic                          load_amount,
	input  logic                          load_key,
	input  logic [9:0]                    sw,
	input  bank_types_pkg::balance_pair_t balances,
	output bank_types_pkg::balance_pair_t new_balances,
	output bank_types_pkg::status_t       status,
	output logic                          done_verify
);

	bank_types_pkg::request_t   req;
	bank_types_pkg::balance_t   payer_bal;
	bank_types_pkg::balance_t   payee_bal;
	bank_types_pkg::balance_t   amount_ext;
	bank_types_pkg::balance_t   payer_after;
	bank_types_pkg::balance_t   payee_after;
	bank_types_pkg::status_t    status_next;
	logic [`BANK_BALANCE_W:0]   payee_sum;
	logic                       key_ok;
	logic                       funds_ok;
	logic                       fits;
	logic                       verify;

	// Payer is taken with the amount, key comes later
	always_ff @(posedge clock) begin
		if (load_amount) begin
			req.amount <= sw[7:0];
			req.payer  <= sw[8];
		end
		if (load_key) begin
			req.key_code <= sw[7:0];
		end
	end

	assign verify      = (step_ctrl.step == bank_ctrl_pkg::step_verify);
	assign done_verify = verify;

	// Route balances by direction
	assign payer_bal  = req.payer ? balances.p2 : balances.p1;
	assign payee_bal  = req.payer ? balances.p1 : balances.p2;
	assign amount_ext = bank_types_pkg::balance_t'(req.amount);

	// Extra bit catches a payee that would wrap
	assign payee_sum   = {1'b0, payee_bal} + {1'b0, amount_ext};
	assign payer_after = payer_bal - amount_ext;
	assign payee_after = payee_sum[`BANK_BALANCE_W-1:0];

	assign key_ok   = (req.key_code == `BANK_KEY_CODE);
	assign funds_ok = (payer_bal >= amount_ext);
	assign fits     = ~payee_sum[`BANK_BALANCE_W];

	// Key first, then funds, then overflow
	always_comb begin
		if (!key_ok) begin
			status_next = bank_types_pkg::status_bad_key;
		end else if (!funds_ok) begin
			status_next = bank_types_pkg::status_no_funds;
		end else if (!fits) begin
			status_next = bank_types_pkg::status_overflow;
		end else begin
			status_next = bank_types_pkg::status_ok;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			status <= bank_types_pkg::status_ok;
		end else if (verify) begin
			status <= status_next;
		end
	end

	// Rejected transfers write back what was read
	always_ff @(posedge clock) begin
		if (verify) begin
			if (status_next != bank_types_pkg::status_ok) begin
				new_balances <= balances;
			end else if (req.payer) begin
				new_balances.p1 <= payee_after;
				new_balances.p2 <= payer_after;
			end else begin
				new_balances.p1 <= payer_after;
				new_balances.p2 <= payee_after;
			end
		end
	end

endmodule

//--- main_control.sv
// Button decode for active-low keys, no debounce; key[1] loads, key[0] starts, key[2] aborts
module main_control (
	input  logic       clock,
	input  logic       rst,
	input  logic [3:0] key,
	input  logic       finished,
	output logic       load_amount,
	output logic       load_key,
	output logic       start_txn,
	output logic       busy
);

	bank_ctrl_pkg::main_state_t state;
	logic [2:0] key_q;
	logic [2:0] key_d;
	logic [2:0] pressed;

	// Two sample stages, released buttons read 1
	always_ff @(posedge clock) begin
		if (rst) begin
			key_q <= 3'b111;
			key_d <= 3'b111;
		end else begin
			key_q <= key[2:0];
			key_d <= key_q;
		end
	end

	// High for one cycle on the 1 to 0 change
	assign pressed = key_d & ~key_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= bank_ctrl_pkg::idle;
			load_amount <= 1'b0;
			load_key    <= 1'b0;
			start_txn   <= 1'b0;
		end else begin
			load_amount <= 1'b0;
			load_key    <= 1'b0;
			start_txn   <= 1'b0;
			case (state)
				bank_ctrl_pkg::idle: begin
					if (pressed[1]) begin
						load_amount <= 1'b1;
						state       <= bank_ctrl_pkg::amount_loaded;
					end
				end
				bank_ctrl_pkg::amount_loaded: begin
					if (pressed[2]) begin
						state <= bank_ctrl_pkg::idle;
					end else if (pressed[1]) begin
						load_key <= 1'b1;
						state    <= bank_ctrl_pkg::key_loaded;
					end
				end
				bank_ctrl_pkg::key_loaded: begin
					if (pressed[2]) begin
						state <= bank_ctrl_pkg::idle;
					end else if (pressed[0]) begin
						start_txn <= 1'b1;
						state     <= bank_ctrl_pkg::busy;
					end
				end
				// Buttons are ignored until the sequencer reports back
				default: begin
					if (finished) state <= bank_ctrl_pkg::idle;
				end
			endcase
		end
	end

	assign busy = (state == bank_ctrl_pkg::busy);

	// Load and start strobes never overlap
	a_one_strobe: assert property (@(posedge clock) disable iff (rst)
		$onehot0({load_amount, load_key, start_txn}));

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bank_main_tb -f bank_main.f \
	&& ./obj_dir/Vbank_main_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- transaction_control.sv
// Step sequencer; read, verify and store wait for done_step, travel runs a fixed count
`include "bank_defines.svh"

module transaction_control (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      start_txn,
	input  logic                      done_step,
	output bank_ctrl_pkg::step_ctrl_t step_ctrl,
	output logic                      finished
);

	localparam int TRAVEL_W = $clog2(`BANK_TRAVEL_CYCLES + 1);

	bank_ctrl_pkg::step_t step_next;
	logic [TRAVEL_W-1:0]  travel_cnt;
	logic                 travel_done;

	// Last travel cycle
	assign travel_done = (travel_cnt == TRAVEL_W'(`BANK_TRAVEL_CYCLES - 1));

	always_comb begin
		step_next = step_ctrl.step;
		case (step_ctrl.step)
			bank_ctrl_pkg::step_idle: begin
				if (start_txn) step_next = bank_ctrl_pkg::step_read;
			end
			bank_ctrl_pkg::step_read: begin
				if (done_step) step_next = bank_ctrl_pkg::step_verify;
			end
			bank_ctrl_pkg::step_verify: begin
				if (done_step) step_next = bank_ctrl_pkg::step_travel;
			end
			bank_ctrl_pkg::step_travel: begin
				if (travel_done) step_next = bank_ctrl_pkg::step_store;
			end
			bank_ctrl_pkg::step_store: begin
				if (done_step) step_next = bank_ctrl_pkg::step_finish;
			end
			default: begin
				step_next = bank_ctrl_pkg::step_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			step_ctrl.step       <= bank_ctrl_pkg::step_idle;
			step_ctrl.step_first <= 1'b0;
			travel_cnt           <= '0;
		end else begin
			step_ctrl.step       <= step_next;
			// Marks the first cycle of whatever step comes next
			step_ctrl.step_first <= (step_next != step_ctrl.step);
			if (step_ctrl.step == bank_ctrl_pkg::step_travel && !travel_done) begin
				travel_cnt <= travel_cnt + 1'b1;
			end else begin
				travel_cnt <= '0;
			end
		end
	end

	// One cycle, then back to idle
	assign finished = (step_ctrl.step == bank_ctrl_pkg::step_finish);

	// A transaction only begins on a start strobe from the decode stage
	a_start_first: assert property (@(posedge clock) disable iff (rst)
		($past(step_ctrl.step) == bank_ctrl_pkg::step_idle &&
		 step_ctrl.step != bank_ctrl_pkg::step_idle) |-> $past(start_txn));

endmodule
